// ==== Makefile ====
VERILATOR  := verilator
FLAGS      := --binary --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_nibble_cpu_top
RTL_TOP    := nibble_cpu_top
FILELIST   := nibble_cpu.f
OBJ_DIR    := obj_dir
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/alu.sv ====
/*
 * alu
 * add, subtract and multiply of registers a and b,
 * all results kept to the low byte
 */

module alu (
  input  nibble_cpu_pkg::opcode_e op,
  input  nibble_cpu_pkg::data_t   a,
  input  nibble_cpu_pkg::data_t   b,
  output nibble_cpu_pkg::data_t   result
);

  import nibble_cpu_pkg::*;

  always_comb begin
    unique case (op)
      OP_ADD: begin
        result = a + b;
      end
      OP_SUB: begin
        result = a - b;
      end
      // 8-bit context drops the upper product byte
      OP_MUL: begin
        result = a * b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== design/cpu_core.sv ====
/*
 * cpu core
 * program counter, decode and the a, b, c register file
 * one instruction per cycle while run is high, holds on an
 * out with no credit left
 */

module cpu_core (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    run,
  input  nibble_cpu_pkg::data_t   instr,
  input  nibble_cpu_pkg::data_t   in_data,
  input  nibble_cpu_pkg::data_t   alu_result,
  input  logic                    credit_ok,
  output nibble_cpu_pkg::pc_t     pc,
  output nibble_cpu_pkg::opcode_e alu_op,
  output nibble_cpu_pkg::data_t   reg_a,
  output nibble_cpu_pkg::data_t   reg_b,
  output logic                    out_fire,
  output nibble_cpu_pkg::data_t   out_value
);

  import nibble_cpu_pkg::*;

  opcode_e opcode;
  nibble_t operand;
  data_t   reg_c;
  logic    reg_sel_ok;
  logic    is_out;
  logic    exec;

  ////////////////////////////////
  // decode
  ////////////////////////////////

  assign opcode  = opcode_e'(instr[7:4]);
  assign operand = instr[3:0];
  assign alu_op  = opcode;

  // operands 3 and up turn IN and OUT into nop
  assign reg_sel_ok = (operand == REG_A_SEL) || (operand == REG_B_SEL) ||
                      (operand == REG_C_SEL);
  assign is_out     = (opcode == OP_OUT) && reg_sel_ok;

  // stall on an out until a credit is back
  assign exec     = run && !(is_out && !credit_ok);
  assign out_fire = exec && is_out;

  always_comb begin
    unique case (operand)
      REG_A_SEL: out_value = reg_a;
      REG_B_SEL: out_value = reg_b;
      REG_C_SEL: out_value = reg_c;
      default:   out_value = '0;
    endcase
  end

  ////////////////////////////////
  // program counter
  ////////////////////////////////

  // wraps 15 to 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (exec) begin
      pc <= pc + pc_t'(1);
    end
  end

  ////////////////////////////////
  // register writeback
  ////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else if (exec) begin
      case (opcode)
        // nibble loads keep the other half
        OP_LDA_LO: reg_a[3:0] <= operand;
        OP_LDA_HI: reg_a[7:4] <= operand;
        OP_LDB_LO: reg_b[3:0] <= operand;
        OP_LDB_HI: reg_b[7:4] <= operand;
        OP_LDC_LO: reg_c[3:0] <= operand;
        OP_LDC_HI: reg_c[7:4] <= operand;
        OP_ADD, OP_SUB, OP_MUL: begin
          reg_c <= alu_result;
        end
        OP_IN: begin
          case (operand)
            REG_A_SEL: reg_a <= in_data;
            REG_B_SEL: reg_b <= in_data;
            REG_C_SEL: reg_c <= in_data;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== design/nibble_cpu_pkg.sv ====
/*
 * nibble cpu shared definitions
 * data, operand, address and credit widths, the opcode set
 * and the constants used across the core and its output port
 */

package nibble_cpu_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////

  // register, memory and port data
  typedef logic [7:0] data_t;
  // low half of an instruction
  typedef logic [3:0] nibble_t;
  // program counter and memory address
  typedef logic [3:0] pc_t;
  // output credit count
  typedef logic [1:0] credit_t;

  ////////////////////////////////
  // constants
  ////////////////////////////////

  localparam int unsigned PROG_DEPTH = 16;
  localparam credit_t OUT_CREDITS = 2'd2;

  // operand values naming a register for IN and OUT
  localparam nibble_t REG_A_SEL = 4'd0;
  localparam nibble_t REG_B_SEL = 4'd1;
  localparam nibble_t REG_C_SEL = 4'd2;

  // high nibble of an instruction where 12 to 15 behave as nop
  typedef enum logic [3:0] {
    OP_NOP    = 4'd0,
    OP_LDA_LO = 4'd1,
    OP_LDA_HI = 4'd2,
    OP_LDB_LO = 4'd3,
    OP_LDB_HI = 4'd4,
    OP_LDC_LO = 4'd5,
    OP_LDC_HI = 4'd6,
    OP_ADD    = 4'd7,
    OP_SUB    = 4'd8,
    OP_MUL    = 4'd9,
    OP_OUT    = 4'd10,
    OP_IN     = 4'd11
  } opcode_e;

endpackage

// ==== design/nibble_cpu_top.sv ====
/*
 * nibble cpu top
 * program memory, core, alu and credit based output port
 */

module nibble_cpu_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  run,
  input  logic                  prog_we,
  input  nibble_cpu_pkg::pc_t   prog_addr,
  input  nibble_cpu_pkg::data_t prog_data,
  input  nibble_cpu_pkg::data_t in_data,
  input  logic                  out_credit,
  output logic                  out_valid,
  output nibble_cpu_pkg::data_t out_data
);

  import nibble_cpu_pkg::*;

  pc_t     pc;
  data_t   instr;
  opcode_e alu_op;
  data_t   reg_a;
  data_t   reg_b;
  data_t   alu_result;
  logic    out_fire;
  data_t   out_value;
  logic    credit_ok;

  program_memory u_program_memory (
    .clk       (clk),
    .arst_n    (arst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  cpu_core u_cpu_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .instr      (instr),
    .in_data    (in_data),
    .alu_result (alu_result),
    .credit_ok  (credit_ok),
    .pc         (pc),
    .alu_op     (alu_op),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .out_fire   (out_fire),
    .out_value  (out_value)
  );

  alu u_alu (
    .op     (alu_op),
    .a      (reg_a),
    .b      (reg_b),
    .result (alu_result)
  );

  output_port u_output_port (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_fire   (out_fire),
    .out_value  (out_value),
    .out_credit (out_credit),
    .credit_ok  (credit_ok),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

// ==== design/output_port.sv ====
/*
 * output port
 * credit counter for the output stream and the registered
 * valid and data seen by the consumer
 */

module output_port (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  out_fire,
  input  nibble_cpu_pkg::data_t out_value,
  input  logic                  out_credit,
  output logic                  credit_ok,
  output logic                  out_valid,
  output nibble_cpu_pkg::data_t out_data
);

  import nibble_cpu_pkg::*;

  credit_t credits;

  // send and return in the same cycle cancel out
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= OUT_CREDITS;
    end else begin
      case ({out_fire, out_credit})
        2'b10:   credits <= credits - credit_t'(1);
        2'b01:   credits <= credits + credit_t'(1);
        default: credits <= credits;
      endcase
    end
  end

  assign credit_ok = (credits != '0);

  // one cycle pulse per executed out
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= out_fire;
      if (out_fire) begin
        out_data <= out_value;
      end
    end
  end

endmodule

// ==== design/program_memory.sv ====
/*
 * program memory
 * sixteen instruction bytes held in flops, loaded through an
 * external write port while the cpu is stopped, read
 * combinationally at the program counter
 */

module program_memory (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  prog_we,
  input  nibble_cpu_pkg::pc_t   prog_addr,
  input  nibble_cpu_pkg::data_t prog_data,
  input  nibble_cpu_pkg::pc_t   pc,
  output nibble_cpu_pkg::data_t instr
);

  import nibble_cpu_pkg::*;

  data_t mem [PROG_DEPTH];

  // external load port clears to all nop on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < PROG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // instruction fetch with no read latency
  assign instr = mem[pc];

endmodule

// ==== nibble_cpu.f ====
design/nibble_cpu_pkg.sv
design/program_memory.sv
design/alu.sv
design/cpu_core.sv
design/output_port.sv
design/nibble_cpu_top.sv
test/tb_nibble_cpu_top.sv

// ==== test/tb_nibble_cpu_top.sv ====
/*
 * nibble cpu testbench
 * loads random programs, runs them against a cycle model of
 * memory, pc, registers and output credits, and checks every
 * output cycle plus the order of emitted values
 */

module tb_nibble_cpu_top;

  import nibble_cpu_pkg::*;

  localparam int NUM_PROGRAMS       = 20;
  localparam int CYCLES_PER_PROGRAM = 60;
  localparam int MARGIN             = 200;
  localparam int TIMEOUT            = (NUM_PROGRAMS * CYCLES_PER_PROGRAM + MARGIN) * 20;

  logic  clk;
  logic  arst_n;
  logic  run;
  logic  prog_we;
  pc_t   prog_addr;
  data_t prog_data;
  data_t in_data;
  logic  out_credit;
  logic  out_valid;
  data_t out_data;

  logic [31:0] lfsr = 32'he363;
  data_t       prog [PROG_DEPTH];
  data_t       exp_q [$];
  int          n_checks;
  int          n_value_err;
  int          n_other_err;
  int          outstanding;

  // model state
  data_t m_mem [PROG_DEPTH];
  pc_t   m_pc;
  data_t m_a;
  data_t m_b;
  data_t m_c;
  int    m_credits;
  logic  exp_valid;
  data_t exp_data;

  nibble_cpu_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .in_data    (in_data),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_outputs();
    data_t want;
    n_checks++;
    assert (out_valid == exp_valid) else begin
      n_value_err++;
      $display("Fail %0t: out_valid %0b, expected %0b", $time, out_valid, exp_valid);
    end
    assert (out_data == exp_data) else begin
      n_value_err++;
      $display("Fail %0t: out_data %02h, expected %02h", $time, out_data, exp_data);
    end
    if (out_valid) begin
      outstanding++;
      assert (outstanding <= int'(OUT_CREDITS)) else begin
        n_other_err++;
        $display("more outputs in flight than credits allow at time %0t", $time);
      end
      assert (exp_q.size() > 0) else begin
        n_other_err++;
        $display("an output appeared with no value expected at time %0t", $time);
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        assert (out_data == want) else begin
          n_value_err++;
          $display("Fail %0t: stream value %02h, expected %02h", $time, out_data, want);
        end
      end
    end
  endtask

  ////////////////////////////////
  // one clock cycle
  ////////////////////////////////

  task automatic step(input logic run_i, input logic we_i, input pc_t addr_i,
                      input data_t data_i, input logic ret_en);
    logic [3:0] op;
    logic [3:0] opd;
    logic       is_out;
    logic       exec;
    logic       fire;
    data_t      sel;
    @(negedge clk);
    check_outputs();
    // consumer hands back credits after a random delay
    out_credit = ret_en && (outstanding > 0) && (rand_bits(1) != 0);
    if (out_credit) begin
      outstanding--;
    end
    run       = run_i;
    prog_we   = we_i;
    prog_addr = addr_i;
    prog_data = data_i;
    in_data   = data_t'(rand_bits(8));
    // predict the coming rising edge
    op     = m_mem[m_pc][7:4];
    opd    = m_mem[m_pc][3:0];
    sel    = (opd == 4'd0) ? m_a : (opd == 4'd1) ? m_b : m_c;
    is_out = (op == OP_OUT) && (opd < 4'd3);
    exec   = run_i && !(is_out && m_credits == 0);
    fire   = exec && is_out;
    exp_valid = fire;
    if (fire) begin
      exp_data = sel;
      exp_q.push_back(sel);
    end
    m_credits = m_credits - int'(fire) + int'(out_credit);
    if (we_i) begin
      m_mem[addr_i] = data_i;
    end
    if (exec) begin
      case (op)
        OP_LDA_LO: m_a = {m_a[7:4], opd};
        OP_LDA_HI: m_a = {opd, m_a[3:0]};
        OP_LDB_LO: m_b = {m_b[7:4], opd};
        OP_LDB_HI: m_b = {opd, m_b[3:0]};
        OP_LDC_LO: m_c = {m_c[7:4], opd};
        OP_LDC_HI: m_c = {opd, m_c[3:0]};
        OP_ADD:    m_c = m_a + m_b;
        OP_SUB:    m_c = m_a - m_b;
        OP_MUL:    m_c = data_t'(m_a * m_b);
        OP_IN: begin
          if (opd == 4'd0) m_a = in_data;
          if (opd == 4'd1) m_b = in_data;
          if (opd == 4'd2) m_c = in_data;
        end
        default: ;
      endcase
      m_pc = m_pc + pc_t'(1);
    end
  endtask

  task automatic run_cycles(input int n, input logic ret_en);
    for (int i = 0; i < n; i++) begin
      step(1'b1, 1'b0, '0, '0, ret_en);
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      step(1'b0, 1'b0, '0, '0, 1'b1);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < PROG_DEPTH; i++) begin
      step(1'b0, 1'b1, pc_t'(i), prog[i], 1'b1);
    end
  endtask

  // 0 nibble loads, 1 arithmetic, 2 in and out, else any byte
  task automatic make_program(input int kind);
    for (int i = 0; i < PROG_DEPTH; i++) begin
      case (kind)
        0: prog[i] = (i >= 13) ? {OP_OUT, 4'(i - 13)} :
                     {4'(1 + rand_bits(3) % 6), nibble_t'(rand_bits(4))};
        1: begin
          if (i % 4 == 3) prog[i] = {OP_OUT, REG_C_SEL};
          else if (i % 4 == 2) prog[i] = {4'(7 + rand_bits(2) % 3), nibble_t'(rand_bits(4))};
          else prog[i] = {4'(1 + rand_bits(2)), nibble_t'(rand_bits(4))};
        end
        2: begin
          if (rand_bits(2) < 3) prog[i] = {3'b101, rand_bits(1) != 0, nibble_t'(rand_bits(2))};
          else prog[i] = {4'(1 + rand_bits(3) % 6), nibble_t'(rand_bits(4))};
        end
        default: prog[i] = data_t'(rand_bits(8));
      endcase
    end
  endtask

  ////////////////////////////////
  // test sequence
  ////////////////////////////////

  initial begin
    arst_n     = 1'b0;
    run        = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    in_data    = '0;
    out_credit = 1'b0;
    m_mem      = '{default: '0};
    m_pc       = '0;
    m_a        = '0;
    m_b        = '0;
    m_c        = '0;
    exp_valid  = 1'b0;
    exp_data   = '0;
    m_credits  = int'(OUT_CREDITS);
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    // quiet while stopped, then out of a from the reset state
    idle_cycles(4);
    prog = '{default: '0};
    prog[0] = {OP_OUT, REG_A_SEL};
    load_program();
    run_cycles(20, 1'b1);
    for (int kind = 0; kind < 3; kind++) begin
      for (int k = 0; k < 4; k++) begin
        make_program(kind);
        load_program();
        run_cycles(24, 1'b1);
      end
    end
    // credits withheld, then returned
    for (int k = 0; k < 3; k++) begin
      make_program(2);
      load_program();
      run_cycles(12, 1'b0);
      run_cycles(24, 1'b1);
    end
    // pause mid program, swap contents, resume at the held pc
    for (int k = 0; k < 2; k++) begin
      make_program(3);
      load_program();
      run_cycles(7, 1'b1);
      idle_cycles(5);
      make_program(3);
      load_program();
      run_cycles(24, 1'b1);
    end
    idle_cycles(8);
    assert (exp_q.size() == 0) else begin
      n_other_err++;
      $display("%0d expected values never appeared on the output", exp_q.size());
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, n_value_err, n_other_err);
    if (n_value_err == 0 && n_other_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
